/* cart_loader_top.f */
+incdir+verilog
verilog/load_pkg.sv
verilog/cart_pkg.sv
verilog/download_decoder.sv
verilog/option_regs.sv
verilog/header_capture.sv
verilog/chip_identify.sv
verilog/cart_loader_top.sv
tests/tb_clock_gen.sv
tests/tb_cart_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cart_loader -f cart_loader_top.f -o sim_cart_loader

./obj_dir/sim_cart_loader > sim.log 2>&1
cat sim.log

if grep -q "Regression passed" sim.log; then
	exit 0
fi
exit 1

/* tests/tb_cart_loader.sv */
// Cartridge loader testbench: random images, reference model, SPC mode and region checks
`timescale 1ns/10ps
`default_nettype none

`include "cart_loader_cfg.svh"

module tb_cart_loader;

	localparam int WATCHDOG_CYCLES = 20000;
	localparam int LOADS_PER_TEST  = 24;
	localparam int PROBE_SPC       = 1;
	localparam int PROBE_PAL       = 2;

	// Mapper/type pairs covering every chip rule; entry 0 gets company B2
	localparam logic [15:0] RULE_HDRS [0:20] = '{
		16'h3005, 16'h2003, 16'h2103, 16'h3005, 16'h3103, 16'h3105, 16'h2005,
		16'h3003, 16'h3025, 16'h3243, 16'h3245, 16'h2013, 16'h2014, 16'h2015,
		16'h201A, 16'h2332, 16'h2334, 16'h2335, 16'h3AF5, 16'h3AF9, 16'h20F3
	};

	logic                    clk_sys;
	logic                    RESET_N;
	load_pkg::ioctl_bus_t    ioctl;
	logic [31:0]             status;
	cart_pkg::cart_profile_t profile;
	logic                    spc_mode;
	logic [1:0]              pal;

	int errors;
	int checks;
	int tests;
	int errors_before;

	tb_clock_gen u_clock_gen (
		.clk_sys (clk_sys),
		.RESET_N (RESET_N)
	);

	cart_loader_top u_cart_loader_top (
		.clk_sys  (clk_sys),
		.RESET_N  (RESET_N),
		.ioctl    (ioctl),
		.status   (status),
		.profile  (profile),
		.spc_mode (spc_mode),
		.pal      (pal)
	);

	// ==================================================
	// Reference model
	// ==================================================
	function automatic logic [3:0] model_chip(input logic [7:0] m, input logic [7:0] t,
			input logic [7:0] c);
		logic [3:0] id;
		case ({m, t})
			16'h3005:                               id = (c == 8'hB2) ?
				cart_pkg::CHIP_DSP3 : cart_pkg::CHIP_DSP1;
			16'h2003, 16'h2103, 16'h3103, 16'h3105: id = cart_pkg::CHIP_DSP1;
			16'h2005:                               id = cart_pkg::CHIP_DSP2;
			16'h3003:                               id = cart_pkg::CHIP_DSP4;
			16'h3025:                               id = cart_pkg::CHIP_OBC1;
			16'h3243, 16'h3245:                     id = cart_pkg::CHIP_SDD1;
			16'h2013, 16'h2014, 16'h2015, 16'h201A: id = cart_pkg::CHIP_GSU;
			16'h2332, 16'h2334, 16'h2335:           id = cart_pkg::CHIP_SA1;
			16'h3AF5, 16'h3AF9:                     id = cart_pkg::CHIP_SPC7110;
			16'h20F3:                               id = cart_pkg::CHIP_CX4;
			default:                                id = cart_pkg::CHIP_NONE;
		endcase
		return id;
	endfunction

	function automatic cart_pkg::cart_profile_t model_profile(input logic [7:0] m,
			input logic [7:0] t, input logic [7:0] c, input logic [3:0] rom_size,
			input logic [3:0] ram_size, input logic [1:0] map);
		cart_pkg::cart_profile_t p;
		logic [3:0]              chip;
		logic [3:0]              rom_code;
		logic [3:0]              ram_code;
		chip     = model_chip(m, t, c);
		rom_code = (rom_size < 4'(`ROM_SIZE_FLOOR)) ? 4'(`ROM_MIN_SIZE_LOG) : rom_size;
		ram_code = (chip == cart_pkg::CHIP_GSU) ? 4'(`GSU_RAM_LOG) : ram_size;
		p.rom_type = {chip, (chip == cart_pkg::CHIP_SPC7110) && t[3], 1'b0, map};
		p.rom_mask = `CART_MASK_W'((32'd1024 << rom_code) - 32'd1);
		p.ram_mask = (ram_code == 4'd0) ? '0 : `CART_MASK_W'((32'd1024 << ram_code) - 32'd1);
		return p;
	endfunction

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [63:0] probe(input int sel);
		case (sel)
			PROBE_SPC: return 64'(spc_mode);
			default:   return 64'(pal);
		endcase
	endfunction

	task automatic wait_value(input int sel, input logic [63:0] exp, input int limit);
		int n;
		n = 0;
		while (probe(sel) != exp && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
	endtask

	task automatic settle_cycles(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("error %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == errors_before) begin
			$display("%s ok", name);
		end else begin
			$display("%s FAILED with %0d errors", name, errors - errors_before);
		end
		errors_before = errors;
	endtask

	// One strobe, then one idle cycle
	task automatic write_word(input logic [`CART_ADDR_W-1:0] addr, input logic [15:0] data);
		ioctl.addr = addr;
		ioctl.data = data;
		ioctl.wr   = 1'b1;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		@(negedge clk_sys);
	endtask

	// ==================================================
	// Tests
	// ==================================================
	task automatic run_cart_test(input bit use_override);
		logic [7:0]              index;
		logic [7:0]              mapper;
		logic [7:0]              ctype;
		logic [7:0]              company;
		logic [3:0]              rom_size;
		logic [3:0]              ram_size;
		logic [1:0]              ovr;
		logic [1:0]              map;
		logic [23:0]             filesize;
		logic [`CART_ADDR_W-1:0] base;
		logic [`CART_ADDR_W-1:0] skip;
		logic [31:0]             st;
		cart_pkg::cart_profile_t exp;
		int                      sel;
		for (int i = 0; i < LOADS_PER_TEST; i++) begin
			sel = int'($urandom % 24);
			if (sel < 21) begin
				{mapper, ctype} = RULE_HDRS[sel];
			end else begin
				{mapper, ctype} = 16'($urandom);
			end
			company  = (sel == 0) ? 8'hB2 : 8'($urandom);
			rom_size = 4'($urandom % 14);
			ram_size = 4'($urandom % 14);
			filesize = {14'($urandom), ($urandom % 2 == 0) ? 10'h000 : 10'h200};
			index    = {2'($urandom), 5'd0, 1'($urandom)};
			ovr      = use_override ? 2'(1 + $urandom % 3) : 2'd0;
			st       = $urandom;
			st[2:1]  = ovr;
			status   = st;
			// Options must be sampled before the download starts
			settle_cycles(2);
			map  = (ovr != 2'd0) ? ovr - 2'd1 : index[7:6];
			base = (map == 2'd1) ? 25'h8000 : (map == 2'd2) ? 25'h408000 : 25'h0;
			skip = `CART_ADDR_W'(filesize[9:0]);
			ioctl.index    = index;
			ioctl.filesize = filesize;
			ioctl.download = 1'b1;
			write_word('0, 16'($urandom));
			write_word(base + `CART_ADDR_W'(`HDR_MAPPER_OFS) + skip, {mapper, 8'($urandom)});
			write_word(base + `CART_ADDR_W'(`HDR_TYPE_OFS) + skip, {4'($urandom), rom_size, ctype});
			write_word(base + `CART_ADDR_W'(`HDR_RAM_OFS) + skip, {12'($urandom), ram_size});
			write_word(base + `CART_ADDR_W'(`HDR_COMPANY_OFS) + skip, {8'($urandom), company});
			ioctl.download = 1'b0;
			exp = model_profile(mapper, ctype, company, rom_size, ram_size, map);
			// Profile is final two cycles after the download level falls
			settle_cycles(2);
			check_val("rom_type", 32'(profile.rom_type), 32'(exp.rom_type));
			check_val("rom_mask", 32'(profile.rom_mask), 32'(exp.rom_mask));
			check_val("ram_mask", 32'(profile.ram_mask), 32'(exp.ram_mask));
		end
	endtask

	task automatic run_spc_test();
		ioctl.filesize = '0;
		ioctl.index    = 8'(`LOAD_IDX_SPC);
		ioctl.download = 1'b1;
		write_word(25'h100, 16'($urandom));
		wait_value(PROBE_SPC, 64'(1), 2);
		check_val("spc_mode", 32'(spc_mode), 32'(1));
		ioctl.download = 1'b0;
		settle_cycles(2);
		ioctl.index    = 8'd0;
		ioctl.download = 1'b1;
		write_word('0, 16'($urandom));
		wait_value(PROBE_SPC, 64'(0), 2);
		check_val("spc_mode", 32'(spc_mode), 32'(0));
		ioctl.download = 1'b0;
		settle_cycles(2);
	endtask

	task automatic run_region_test();
		logic [1:0]  r0;
		logic [1:0]  r1;
		logic [31:0] st;
		r0        = 2'($urandom);
		r1        = r0 + 2'(1 + $urandom % 3);
		st        = $urandom;
		st[15:14] = r0;
		status    = st;
		wait_value(PROBE_PAL, 64'(r0), 4);
		check_val("pal", 32'(pal), 32'(r0));
		ioctl.index    = 8'd1;
		ioctl.download = 1'b1;
		status[15:14]  = r1;
		// Region is frozen while the image streams in
		for (int i = 0; i < 4; i++) begin
			@(negedge clk_sys);
			check_val("pal", 32'(pal), 32'(r0));
		end
		ioctl.download = 1'b0;
		wait_value(PROBE_PAL, 64'(r1), 2);
		check_val("pal", 32'(pal), 32'(r1));
	endtask

	initial begin
		for (int c = 0; c < WATCHDOG_CYCLES; c++) begin
			@(posedge clk_sys);
		end
		$display("Simulation timed out before all tests finished");
		$display("Regression failed");
		$finish;
	end

	initial begin
		int n;
		void'($urandom(32'hdeca_ba76));
		ioctl         = '0;
		status        = '0;
		errors        = 0;
		checks        = 0;
		tests         = 0;
		errors_before = 0;
		n = 0;
		while (!RESET_N && n < 50) begin
			@(negedge clk_sys);
			n++;
		end
		if (!RESET_N) begin
			$display("Reset was never released");
			errors++;
		end
		settle_cycles(1);
		check_val("spc_mode", 32'(spc_mode), 32'(0));
		check_val("rom_type", 32'(profile.rom_type), 32'(0));
		check_val("rom_mask", 32'(profile.rom_mask), 32'(0));
		check_val("ram_mask", 32'(profile.ram_mask), 32'(0));
		finish_test("reset values");
		run_cart_test(1'b0);
		finish_test("random cartridge images");
		run_cart_test(1'b1);
		finish_test("map override images");
		run_spc_test();
		finish_test("spc mode");
		run_region_test();
		finish_test("video region");
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// Testbench clock generator and synchronous reset sequence
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_sys,
	output logic RESET_N
);

	// 40 ns period
	initial begin
		clk_sys = 1'b0;
		forever begin
			#HALF_PERIOD clk_sys = ~clk_sys;
		end
	end

	// Reset held for the first cycles, released on a falling edge
	initial begin
		RESET_N = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk_sys);
		end
		@(negedge clk_sys);
		RESET_N = 1'b1;
	end

endmodule

`default_nettype wire

/* verilog/cart_loader_cfg.svh */
// Cartridge loader widths, header offsets, mask limits and load indices
`ifndef CART_LOADER_CFG_SVH
`define CART_LOADER_CFG_SVH

// ==================================================
// Loader bus widths
// ==================================================
`define CART_ADDR_W 25
`define CART_DATA_W 16
`define CART_MASK_W 24

// ==================================================
// Header offsets inside the header bank
// ==================================================
`define HDR_MAPPER_OFS  16'h7FD4
`define HDR_TYPE_OFS    16'h7FD6
`define HDR_RAM_OFS     16'h7FD8
`define HDR_COMPANY_OFS 16'h7FDA

// Size codes below this floor are raised to the minimum
`define ROM_SIZE_FLOOR   7
`define ROM_MIN_SIZE_LOG 12

// RAM size code forced for GSU carts
`define GSU_RAM_LOG 6

// Loader index of a sound program image
`define LOAD_IDX_SPC 2

`endif

/* verilog/cart_loader_top.sv */
// Cartridge loader top level: decoder, options, header capture, chip id
`timescale 1ns/10ps
`default_nettype none

module cart_loader_top (
	input  logic                    clk_sys,
	input  logic                    RESET_N,
	input  load_pkg::ioctl_bus_t    ioctl,
	input  logic [31:0]             status,
	output cart_pkg::cart_profile_t profile,
	output logic                    spc_mode,
	output logic [1:0]              pal
);

	load_pkg::load_ctl_t   load_ctl;
	logic                  downloading;
	cart_pkg::cart_opts_t  opts;
	cart_pkg::hdr_fields_t fields;

	download_decoder u_download_decoder (
		.clk_sys     (clk_sys),
		.RESET_N     (RESET_N),
		.ioctl       (ioctl),
		.load_ctl    (load_ctl),
		.downloading (downloading),
		.spc_mode    (spc_mode)
	);

	option_regs u_option_regs (
		.clk_sys     (clk_sys),
		.RESET_N     (RESET_N),
		.status      (status),
		.downloading (downloading),
		.opts        (opts),
		.pal         (pal)
	);

	header_capture u_header_capture (
		.clk_sys  (clk_sys),
		.RESET_N  (RESET_N),
		.load_ctl (load_ctl),
		.opts     (opts),
		.fields   (fields)
	);

	chip_identify u_chip_identify (
		.clk_sys  (clk_sys),
		.RESET_N  (RESET_N),
		.load_ctl (load_ctl),
		.fields   (fields),
		.profile  (profile)
	);

endmodule

`default_nettype wire

/* verilog/cart_pkg.sv */
// Cartridge types: header word union, header fields, options, chip ids, profile
`default_nettype none

`include "cart_loader_cfg.svh"

package cart_pkg;

	// One loader data word, seen as bytes or as the size/type pair
	typedef union packed {
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
		struct packed {
			logic [3:0] spare;
			logic [3:0] rom_size;
			logic [7:0] cart_type;
		} size_type;
	} hdr_word_u;

	// Header bytes latched during a cartridge load
	typedef struct packed {
		logic [7:0] mapper;
		logic [7:0] cart_type;
		logic [7:0] company;
		logic [3:0] rom_size;
		logic [3:0] ram_size;
		logic [1:0] map_mode;
	} hdr_fields_t;

	// User options; override 0 means auto
	typedef struct packed {
		logic [1:0] map_override;
		logic [1:0] video_region;
	} cart_opts_t;

	// ==================================================
	// Coprocessor codes as seen in rom_type[7:4]
	// ==================================================
	typedef enum logic [3:0] {
		CHIP_NONE    = 4'h0,
		CHIP_CX4     = 4'h4,
		CHIP_SDD1    = 4'h5,
		CHIP_SA1     = 4'h6,
		CHIP_GSU     = 4'h7,
		CHIP_DSP1    = 4'h8,
		CHIP_DSP2    = 4'h9,
		CHIP_DSP3    = 4'hA,
		CHIP_DSP4    = 4'hB,
		CHIP_OBC1    = 4'hC,
		CHIP_SPC7110 = 4'hD
	} chip_id_e;

	typedef struct packed {
		logic [7:0]              rom_type;
		logic [`CART_MASK_W-1:0] rom_mask;
		logic [`CART_MASK_W-1:0] ram_mask;
	} cart_profile_t;

endpackage

`default_nettype wire

/* verilog/chip_identify.sv */
// Chip identification and ROM/RAM mask generation from the captured header
`timescale 1ns/10ps
`default_nettype none

`include "cart_loader_cfg.svh"

module chip_identify (
	input  logic                    clk_sys,
	input  logic                    RESET_N,
	input  load_pkg::load_ctl_t     load_ctl,
	input  cart_pkg::hdr_fields_t   fields,
	output cart_pkg::cart_profile_t profile
);

	cart_pkg::chip_id_e      chip;
	logic [3:0]              rom_code;
	logic [3:0]              ram_code;
	logic                    rtc_bit;
	logic [`CART_MASK_W-1:0] rom_mask_nxt;
	logic [`CART_MASK_W-1:0] ram_mask_nxt;
	logic                    loaded;

	// ==================================================
	// Chip rules, first match wins
	// ==================================================
	function automatic cart_pkg::chip_id_e decode_chip(input cart_pkg::hdr_fields_t f);
		logic [7:0]         m;
		logic [7:0]         t;
		cart_pkg::chip_id_e id;
		m = f.mapper;
		t = f.cart_type;
		if (m == 8'h30 && t == 8'h05 && f.company == 8'hB2) begin
			id = cart_pkg::CHIP_DSP3;
		end else if (((m == 8'h20 || m == 8'h21) && t == 8'h03) ||
				(m == 8'h30 && t == 8'h05) ||
				(m == 8'h31 && (t == 8'h03 || t == 8'h05))) begin
			id = cart_pkg::CHIP_DSP1;
		end else if (m == 8'h20 && t == 8'h05) begin
			id = cart_pkg::CHIP_DSP2;
		end else if (m == 8'h30 && t == 8'h03) begin
			id = cart_pkg::CHIP_DSP4;
		end else if (m == 8'h30 && t == 8'h25) begin
			id = cart_pkg::CHIP_OBC1;
		end else if (m == 8'h32 && (t == 8'h43 || t == 8'h45)) begin
			id = cart_pkg::CHIP_SDD1;
		end else if (m == 8'h20 &&
				(t == 8'h13 || t == 8'h14 || t == 8'h15 || t == 8'h1A)) begin
			id = cart_pkg::CHIP_GSU;
		end else if (m == 8'h23 && (t == 8'h32 || t == 8'h34 || t == 8'h35)) begin
			id = cart_pkg::CHIP_SA1;
		end else if (m == 8'h3A && (t == 8'hF5 || t == 8'hF9)) begin
			id = cart_pkg::CHIP_SPC7110;
		end else if (m == 8'h20 && t == 8'hF3) begin
			id = cart_pkg::CHIP_CX4;
		end else begin
			id = cart_pkg::CHIP_NONE;
		end
		return id;
	endfunction

	assign chip = decode_chip(fields);

	// SPC7110 type F9 has the RTC, seen in type bit 3
	assign rtc_bit = (chip == cart_pkg::CHIP_SPC7110) ? fields.cart_type[3] : 1'b0;

	// Tiny size codes are raised to the minimum ROM size
	assign rom_code = (fields.rom_size < 4'(`ROM_SIZE_FLOOR)) ?
		4'(`ROM_MIN_SIZE_LOG) : fields.rom_size;

	// GSU boards carry a fixed save RAM whatever the header says
	assign ram_code = (chip == cart_pkg::CHIP_GSU) ? 4'(`GSU_RAM_LOG) : fields.ram_size;

	assign rom_mask_nxt = (`CART_MASK_W'(1024) << rom_code) - `CART_MASK_W'(1);
	assign ram_mask_nxt = (ram_code == 4'd0) ? '0 :
		(`CART_MASK_W'(1024) << ram_code) - `CART_MASK_W'(1);

	// ==================================================
	// Profile register
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			loaded  <= 1'b0;
			profile <= '0;
		end else begin
			// Profile stays at zero until some cartridge image has arrived
			if (load_ctl.wr && load_ctl.cart) begin
				loaded <= 1'b1;
			end
			if (!load_ctl.cart && loaded) begin
				profile.rom_type <= {chip, rtc_bit, 1'b0, fields.map_mode};
				profile.rom_mask <= rom_mask_nxt;
				profile.ram_mask <= ram_mask_nxt;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/download_decoder.sv */
// Download decoder: bus register, load classification, header skip, SPC mode
`timescale 1ns/10ps
`default_nettype none

`include "cart_loader_cfg.svh"

module download_decoder (
	input  logic                 clk_sys,
	input  logic                 RESET_N,
	input  load_pkg::ioctl_bus_t ioctl,
	output load_pkg::load_ctl_t  load_ctl,
	output logic                 downloading,
	output logic                 spc_mode
);

	logic                    cart_load;
	logic                    spc_load;
	logic [`CART_ADDR_W-1:0] addr_adj;

	// Index 0 and 1 are cartridge images, bits 7:6 carry the map
	assign cart_load = ioctl.download && (ioctl.index[5:1] == 5'd0);
	assign spc_load  = ioctl.download && (ioctl.index[5:0] == 6'(`LOAD_IDX_SPC));

	// Copier header is whatever the file size has beyond a 1 KiB multiple
	assign addr_adj = ioctl.addr - `CART_ADDR_W'(ioctl.filesize[9:0]);

	// Level goes straight to the option register
	assign downloading = ioctl.download;

	// ==================================================
	// Bus register
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			load_ctl.wr   <= 1'b0;
			load_ctl.cart <= 1'b0;
			load_ctl.spc  <= 1'b0;
		end else begin
			load_ctl.wr   <= ioctl.wr;
			load_ctl.cart <= cart_load;
			load_ctl.spc  <= spc_load;
		end
	end

	// Payload has no reset
	always_ff @(posedge clk_sys) begin
		load_ctl.addr     <= ioctl.addr;
		load_ctl.addr_adj <= addr_adj;
		load_ctl.data     <= ioctl.data;
		load_ctl.map      <= ioctl.index[7:6];
	end

	// Last written image decides whether the core runs as SPC player
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			spc_mode <= 1'b0;
		end else if (load_ctl.wr) begin
			spc_mode <= load_ctl.spc;
		end
	end

endmodule

`default_nettype wire

/* verilog/header_capture.sv */
// Header capture: memory map choice and header field latches
`timescale 1ns/10ps
`default_nettype none

`include "cart_loader_cfg.svh"

module header_capture (
	input  logic                  clk_sys,
	input  logic                  RESET_N,
	input  load_pkg::load_ctl_t   load_ctl,
	input  cart_pkg::cart_opts_t  opts,
	output cart_pkg::hdr_fields_t fields
);

	localparam logic [`CART_ADDR_W-1:0] BASE_LOROM   = `CART_ADDR_W'(0);
	localparam logic [`CART_ADDR_W-1:0] BASE_HIROM   = `CART_ADDR_W'('h8000);
	localparam logic [`CART_ADDR_W-1:0] BASE_EXHIROM = `CART_ADDR_W'('h408000);

	logic [1:0]              sel_map;
	logic [`CART_ADDR_W-1:0] hdr_base;
	cart_pkg::hdr_word_u     hdr_word;
	logic                    cart_wr;
	logic                    hit_mapper;
	logic                    hit_type;
	logic                    hit_ram;
	logic                    hit_company;

	// Manual override wins, else the map bits of the loader index
	assign sel_map = (opts.map_override != 2'd0) ? (opts.map_override - 2'd1) : load_ctl.map;

	// Header bank for the map latched at image start
	always_comb begin
		case (fields.map_mode)
			2'd1:    hdr_base = BASE_HIROM;
			2'd2:    hdr_base = BASE_EXHIROM;
			default: hdr_base = BASE_LOROM;
		endcase
	end

	assign hdr_word = load_ctl.data;
	assign cart_wr  = load_ctl.wr && load_ctl.cart;

	// ==================================================
	// Header address match
	// ==================================================
	assign hit_mapper  = load_ctl.addr_adj == hdr_base + `CART_ADDR_W'(`HDR_MAPPER_OFS);
	assign hit_type    = load_ctl.addr_adj == hdr_base + `CART_ADDR_W'(`HDR_TYPE_OFS);
	assign hit_ram     = load_ctl.addr_adj == hdr_base + `CART_ADDR_W'(`HDR_RAM_OFS);
	assign hit_company = load_ctl.addr_adj == hdr_base + `CART_ADDR_W'(`HDR_COMPANY_OFS);

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			fields <= '0;
		end else if (cart_wr) begin
			// First word of a new image
			if (load_ctl.addr == '0) begin
				fields.map_mode <= sel_map;
				fields.ram_size <= 4'd0;
			end
			if (hit_mapper) begin
				fields.mapper <= hdr_word.bytes.hi;
			end
			// Size nibble shares the word with the type byte
			if (hit_type) begin
				fields.rom_size  <= hdr_word.size_type.rom_size;
				fields.cart_type <= hdr_word.size_type.cart_type;
			end
			if (hit_ram) begin
				fields.ram_size <= hdr_word.bytes.lo[3:0];
			end
			if (hit_company) begin
				fields.company <= hdr_word.bytes.lo;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/load_pkg.sv */
// Download stream types: loader bus and registered load control
`default_nettype none

`include "cart_loader_cfg.svh"

package load_pkg;

	// Loader bus as driven by the image source
	typedef struct packed {
		logic                    wr;
		logic [`CART_ADDR_W-1:0] addr;
		logic [`CART_DATA_W-1:0] data;
		logic                    download;
		logic [7:0]              index;
		logic [23:0]             filesize;
	} ioctl_bus_t;

	// Decoded and registered view of one loader cycle
	typedef struct packed {
		logic                    wr;
		logic                    cart;
		logic                    spc;
		logic [`CART_ADDR_W-1:0] addr;
		// Address with the copier header removed
		logic [`CART_ADDR_W-1:0] addr_adj;
		logic [`CART_DATA_W-1:0] data;
		logic [1:0]              map;
	} load_ctl_t;

endpackage

`default_nettype wire

/* verilog/option_regs.sv */
// Option register: map override and video region sampled from status
`timescale 1ns/10ps
`default_nettype none

module option_regs (
	input  logic                 clk_sys,
	input  logic                 RESET_N,
	input  logic [31:0]          status,
	input  logic                 downloading,
	output cart_pkg::cart_opts_t opts,
	output logic [1:0]           pal
);

	// Options freeze while an image streams in
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			opts <= '0;
		end else if (!downloading) begin
			opts.map_override <= status[2:1];
			opts.video_region <= status[15:14];
		end
	end

	// Region to the video side, one more stage
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			pal <= 2'b00;
		end else begin
			pal <= opts.video_region;
		end
	end

endmodule

`default_nettype wire
